//--- source/vga_pkg.sv
// VGA scan-out shared definitions
// Mode timing for 800x600, the centred graphics window, fetch segment sizes
// and the types that travel between the timing, fetch, buffer and output blocks

package vga_pkg;

  // Raster counter value
  typedef logic [10:0] coord_t;
  // 1:5:5:5 pixel, bit 15 unused
  typedef logic [15:0] pix_t;
  // External data word, low half is the left pixel
  typedef logic [31:0] mem_word_t;
  typedef logic [23:0] byte_addr_t;
  typedef logic [7:0]  burst_len_t;
  // Top bit selects the buffer half
  typedef logic [8:0]  lb_word_addr_t;
  typedef logic [9:0]  lb_pix_addr_t;

  typedef struct packed {
    coord_t hc;
    coord_t vc;
  } raster_t;

  typedef struct packed {
    logic       rd;
    byte_addr_t addr;
    burst_len_t burst_dw;
  } mem_req_t;

  typedef struct packed {
    logic          en;
    lb_word_addr_t addr;
    mem_word_t     data;
  } lb_wr_t;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_BURST
  } fetch_state_t;

  // 800x600 mode, sync pulses active low
  localparam int H_ACTIVE     = 800;
  localparam int H_SYNC_START = 840;
  localparam int H_SYNC_END   = 968;
  localparam int H_TOTAL      = 1056;
  localparam int V_ACTIVE     = 600;
  localparam int V_SYNC_START = 601;
  localparam int V_SYNC_END   = 605;
  localparam int V_TOTAL      = 628;
  localparam logic HSYNC_POL  = 1'b0;
  localparam logic VSYNC_POL  = 1'b0;

  // Centred graphics window
  localparam int WIN_W           = 320;
  localparam int WIN_H           = 240;
  localparam int WIN_X1          = (H_ACTIVE - WIN_W) / 2;
  localparam int WIN_X2          = WIN_X1 + WIN_W;
  localparam int WIN_Y1          = (V_ACTIVE - WIN_H) / 2;
  localparam int WIN_Y2          = WIN_Y1 + WIN_H;
  localparam int BYTES_PER_PIXEL = 2;
  localparam int LINE_BYTES      = WIN_W * BYTES_PER_PIXEL;

  // One burst fetches one 64-pixel segment
  localparam int SEG_PIXELS    = 64;
  localparam int SEG_BYTES     = SEG_PIXELS * BYTES_PER_PIXEL;
  localparam int SEG_WORDS     = SEG_BYTES / ($bits(mem_word_t) / 8);
  localparam int SEGS_PER_LINE = WIN_W / SEG_PIXELS;

endpackage

//--- source/video_timing.sv
// Video timing generator
// Free-running horizontal and vertical raster counters with hsync, vsync
// and display enable decoded from the mode constants

`timescale 1ns/10ps

module video_timing (
  input  logic             vclk,
  input  logic             resetn,
  output vga_pkg::raster_t pos,
  output logic             hsync,
  output logic             vsync,
  output logic             de
);
  import vga_pkg::*;

  coord_t hc;
  coord_t vc;
  logic   in_hsync;
  logic   in_vsync;

  // hc runs every cycle, vc steps on hc wrap
  always_ff @(posedge vclk or negedge resetn) begin
    if (!resetn) begin
      hc <= '0;
      vc <= '0;
    end else if (hc == coord_t'(H_TOTAL - 1)) begin
      hc <= '0;
      if (vc == coord_t'(V_TOTAL - 1)) begin
        vc <= '0;
      end else begin
        vc <= vc + coord_t'(1);
      end
    end else begin
      hc <= hc + coord_t'(1);
    end
  end

  assign pos.hc = hc;
  assign pos.vc = vc;

  assign in_hsync = (hc >= coord_t'(H_SYNC_START)) && (hc < coord_t'(H_SYNC_END));
  assign in_vsync = (vc >= coord_t'(V_SYNC_START)) && (vc < coord_t'(V_SYNC_END));

  // Pulse carries the mode polarity, idle level is its inverse
  assign hsync = in_hsync ? HSYNC_POL : ~HSYNC_POL;
  assign vsync = in_vsync ? VSYNC_POL : ~VSYNC_POL;

  assign de = (hc < coord_t'(H_ACTIVE)) && (vc < coord_t'(V_ACTIVE));

endmodule

//--- source/line_fetch.sv
// Line fetch engine
// Issues one burst per 64-pixel segment for the window line after the one
// on screen and writes the returned words into the idle line-buffer half

`timescale 1ns/10ps

module line_fetch (
  input  logic                vclk,
  input  logic                resetn,
  input  vga_pkg::raster_t    pos,
  input  logic                fetch_en,
  input  vga_pkg::byte_addr_t fb_base,
  input  vga_pkg::mem_word_t  ext_rdata,
  input  logic                ext_burst_ready,
  output vga_pkg::mem_req_t   ext_req,
  output vga_pkg::lb_wr_t     lb_wr
);
  import vga_pkg::*;

  fetch_state_t  state;
  logic          rd_pulse;
  byte_addr_t    req_addr;
  burst_len_t    word_cnt;
  logic          last_word;

  lb_word_addr_t wr_ptr;
  logic          wr_en;
  lb_word_addr_t wr_addr;
  mem_word_t     wr_data;

  coord_t        fetch_row;
  coord_t        win_line;
  coord_t        seg_idx;
  logic [$bits(lb_word_addr_t)-2:0] seg_offset;
  logic          in_rows;
  logic          seg_start;
  logic          take_word;

  // Row relative to the window top, one line ahead of the display
  assign fetch_row = pos.vc - coord_t'(WIN_Y1);
  assign win_line  = fetch_row + coord_t'(1);

  assign seg_idx    = pos.hc / coord_t'(SEG_PIXELS);
  assign seg_offset = ($bits(seg_offset))'(seg_idx * coord_t'(SEG_WORDS));

  assign in_rows = (pos.vc >= coord_t'(WIN_Y1 - 1)) && (pos.vc < coord_t'(WIN_Y2 - 1));

  // A trigger while a burst is still open is dropped
  assign seg_start = (state == FETCH_IDLE) && fetch_en && in_rows
                   && ((pos.hc % coord_t'(SEG_PIXELS)) == '0)
                   && (seg_idx < coord_t'(SEGS_PER_LINE));

  assign take_word = (state == FETCH_BURST) && ext_burst_ready;
  assign last_word = (word_cnt == burst_len_t'(SEG_WORDS - 1));

  always_ff @(posedge vclk or negedge resetn) begin
    if (!resetn) begin
      state    <= FETCH_IDLE;
      rd_pulse <= 1'b0;
      wr_en    <= 1'b0;
      word_cnt <= '0;
    end else begin
      rd_pulse <= 1'b0;
      wr_en    <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          if (seg_start) begin
            rd_pulse <= 1'b1;
            word_cnt <= '0;
            state    <= FETCH_BURST;
          end
        end
        FETCH_BURST: begin
          if (ext_burst_ready) begin
            wr_en    <= 1'b1;
            word_cnt <= word_cnt + burst_len_t'(1);
            // Segment complete after the last strobe
            if (last_word) begin
              state <= FETCH_IDLE;
            end
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

  // Burst address and buffer placement, latched at the trigger
  always_ff @(posedge vclk) begin
    if (seg_start) begin
      req_addr <= fb_base
                + byte_addr_t'(win_line) * byte_addr_t'(LINE_BYTES)
                + byte_addr_t'(seg_idx) * byte_addr_t'(SEG_BYTES);
      wr_ptr   <= {fetch_row[0], seg_offset};
    end
    if (take_word) begin
      wr_addr <= wr_ptr;
      wr_data <= ext_rdata;
      wr_ptr  <= wr_ptr + lb_word_addr_t'(1);
    end
  end

  assign ext_req.rd       = rd_pulse;
  assign ext_req.addr     = req_addr;
  assign ext_req.burst_dw = burst_len_t'(SEG_WORDS);

  assign lb_wr.en   = wr_en;
  assign lb_wr.addr = wr_addr;
  assign lb_wr.data = wr_data;

endmodule

//--- source/line_buffer.sv
// Ping-pong line buffer
// Two halves of 256 words, written a word at a time by the fetch engine
// and read back one pixel per cycle with one cycle of latency

`timescale 1ns/10ps

module line_buffer (
  input  logic                  vclk,
  input  vga_pkg::lb_wr_t       wr,
  input  vga_pkg::lb_pix_addr_t rd_addr,
  output vga_pkg::pix_t         rd_data
);
  import vga_pkg::*;

  mem_word_t mem [0:(1 << $bits(lb_word_addr_t)) - 1];

  mem_word_t rd_word;
  logic      rd_odd;

  always_ff @(posedge vclk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Word read registered, pixel picked from it afterwards
  always_ff @(posedge vclk) begin
    rd_word <= mem[rd_addr[$bits(lb_pix_addr_t)-1:1]];
    rd_odd  <= rd_addr[0];
  end

  // Even pixel sits in the low half
  assign rd_data = rd_odd ? rd_word[31:16] : rd_word[15:0];

endmodule

//--- source/pixel_out.sv
// Pixel output stage
// Walks the line-buffer half for the current window line and splits each
// pixel into RGB, forcing black outside the window

`timescale 1ns/10ps

module pixel_out (
  input  logic                  vclk,
  input  logic                  resetn,
  input  vga_pkg::raster_t      pos,
  output vga_pkg::lb_pix_addr_t rd_addr,
  input  vga_pkg::pix_t         rd_data,
  output logic [4:0]            red,
  output logic [4:0]            green,
  output logic [4:0]            blue
);
  import vga_pkg::*;

  coord_t disp_row;
  logic   in_rows;
  logic   advance;
  logic   in_win;

  assign disp_row = pos.vc - coord_t'(WIN_Y1);
  assign in_rows  = (pos.vc >= coord_t'(WIN_Y1)) && (pos.vc < coord_t'(WIN_Y2));

  // Start one cycle early to cover the RAM read latency
  assign advance = in_rows && (pos.hc >= coord_t'(WIN_X1 - 1)) && (pos.hc < coord_t'(WIN_X2));
  assign in_win  = in_rows && (pos.hc >= coord_t'(WIN_X1)) && (pos.hc < coord_t'(WIN_X2));

  always_ff @(posedge vclk or negedge resetn) begin
    if (!resetn) begin
      rd_addr <= '0;
    end else if (pos.hc == '0) begin
      // Line y lives in the half of parity y - 1
      rd_addr <= {~disp_row[0], {($bits(lb_pix_addr_t) - 1){1'b0}}};
    end else if (advance) begin
      rd_addr <= rd_addr + lb_pix_addr_t'(1);
    end
  end

  assign red   = in_win ? rd_data[14:10] : 5'd0;
  assign green = in_win ? rd_data[9:5] : 5'd0;
  assign blue  = in_win ? rd_data[4:0] : 5'd0;

endmodule

//--- source/vga_scanout.sv
// VGA scan-out top level
// Video timing drives both the line fetch engine, which fills the
// ping-pong line buffer from external memory, and the pixel output stage

`timescale 1ns/10ps

module vga_scanout (
  input  logic                vclk,
  input  logic                resetn,
  input  logic                fetch_en,
  input  vga_pkg::byte_addr_t fb_base,
  input  vga_pkg::mem_word_t  ext_rdata,
  input  logic                ext_burst_ready,
  output vga_pkg::mem_req_t   ext_req,
  output logic [4:0]          red,
  output logic [4:0]          green,
  output logic [4:0]          blue,
  output logic                hsync,
  output logic                vsync,
  output logic                de
);
  import vga_pkg::*;

  raster_t      pos;
  lb_wr_t       lb_wr;
  lb_pix_addr_t lb_rd_addr;
  pix_t         lb_rd_data;

  video_timing u_timing (
    .vclk   (vclk),
    .resetn (resetn),
    .pos    (pos),
    .hsync  (hsync),
    .vsync  (vsync),
    .de     (de)
  );

  line_fetch u_fetch (
    .vclk            (vclk),
    .resetn          (resetn),
    .pos             (pos),
    .fetch_en        (fetch_en),
    .fb_base         (fb_base),
    .ext_rdata       (ext_rdata),
    .ext_burst_ready (ext_burst_ready),
    .ext_req         (ext_req),
    .lb_wr           (lb_wr)
  );

  line_buffer u_lbuf (
    .vclk    (vclk),
    .wr      (lb_wr),
    .rd_addr (lb_rd_addr),
    .rd_data (lb_rd_data)
  );

  pixel_out u_pix (
    .vclk    (vclk),
    .resetn  (resetn),
    .pos     (pos),
    .rd_addr (lb_rd_addr),
    .rd_data (lb_rd_data),
    .red     (red),
    .green   (green),
    .blue    (blue)
  );

endmodule

//--- test/fb_mem_model.sv
// Framebuffer memory model
// Answers each burst read with a generated pattern after a random latency
// and with random one-cycle gaps, and checks every request against the fetch order

`timescale 1ns/10ps

module fb_mem_model (
  input  logic                vclk,
  input  logic                resetn,
  input  logic                vsync,
  input  logic                fetch_en,
  input  vga_pkg::byte_addr_t fb_base,
  input  logic [15:0]         key,
  input  vga_pkg::mem_req_t   req,
  output vga_pkg::mem_word_t  rdata,
  output logic                ready,
  output logic                fault
);
  import vga_pkg::*;

  localparam int MAX_GAPS = 24;

  logic [15:0] lfsr = 16'd18556;
  int          req_count;
  int          exp_count;
  int          words_left;
  logic        frame_en;
  logic        vsync_prev;
  byte_addr_t  exp_addr;

  // Taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  // Each half-word holds its address bits 16..1 under the key
  function automatic logic [15:0] half_at(input byte_addr_t a);
    return a[16:1] ^ key;
  endfunction

  task automatic report_fault(input string msg);
    $display("%s", msg);
    fault = 1'b1;
  endtask

  // Latency of 2 to 5 cycles, then one word per strobe
  task automatic serve_burst(input byte_addr_t base, input int n);
    int lat;
    int gap;
    int gaps;
    int w;
    gaps = 0;
    take_bits(2, lat);
    repeat (lat + 1) @(posedge vclk);
    for (w = 0; w < n; w++) begin
      ready <= 1'b1;
      rdata <= {half_at(base + byte_addr_t'(4 * w + 2)), half_at(base + byte_addr_t'(4 * w))};
      @(posedge vclk);
      if (w < n - 1 && gaps < MAX_GAPS) begin
        take_bits(1, gap);
        if (gap != 0) begin
          ready <= 1'b0;
          gaps++;
          @(posedge vclk);
        end
      end
    end
    ready <= 1'b0;
  endtask

  initial begin
    ready <= 1'b0;
    rdata <= '0;
    forever begin
      @(posedge vclk);
      if (resetn && req.rd) begin
        serve_burst(req.addr, int'(req.burst_dw));
      end
    end
  end

  always @(posedge vclk) begin
    if (!resetn) begin
      fault      = 1'b0;
      req_count  = 0;
      words_left = 0;
      frame_en   = 1'b0;
    end else begin
      // A frame fetches every window line or none of them
      if (vsync_prev && !vsync) begin
        exp_count = frame_en ? WIN_H * SEGS_PER_LINE : 0;
        assert (req_count == exp_count) else
          report_fault($sformatf("ERR %0t ns request count expected %0d got %0d",
                                 $time, exp_count, req_count));
        req_count = 0;
      end
      if (!vsync) frame_en = fetch_en;
      if (ready) words_left--;
      if (req.rd) begin
        exp_addr = fb_base + byte_addr_t'((req_count / SEGS_PER_LINE) * LINE_BYTES
                 + (req_count % SEGS_PER_LINE) * SEG_BYTES);
        assert (fetch_en) else
          report_fault($sformatf("Read request at %0t ns while fetching is off", $time));
        assert (words_left == 0) else
          report_fault($sformatf("Read request at %0t ns while a burst is open", $time));
        assert (req.burst_dw == burst_len_t'(SEG_WORDS)) else
          report_fault($sformatf("ERR %0t ns ext_req.burst_dw expected %0d got %0d",
                                 $time, SEG_WORDS, req.burst_dw));
        assert (req.addr == exp_addr) else
          report_fault($sformatf("ERR %0t ns ext_req.addr expected %06h got %06h",
                                 $time, exp_addr, req.addr));
        words_left = int'(req.burst_dw);
        req_count++;
      end
    end
    vsync_prev = vsync;
  end

endmodule

//--- test/tb_vga_scanout.sv
// Testbench for the VGA scan-out engine
// Runs a table of framebuffer settings over several frames and checks sync
// timing, display enable, window pixels and the black border

`timescale 1ns/10ps

module tb_vga_scanout;
  import vga_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_ROWS   = 4;

  typedef struct packed {
    byte_addr_t  base;
    logic [15:0] key;
    logic        en;
    logic [3:0]  frames;
  } stim_row_t;

  // Columns are framebuffer base, data key, fetch enable and frame count
  localparam stim_row_t STIM_TAB [NUM_ROWS] = '{
    '{24'h012340, 16'h0000, 1'b1, 4'd2},
    '{24'h3a5c00, 16'h5a3c, 1'b1, 4'd1},
    '{24'h7f0000, 16'hffff, 1'b0, 4'd1},
    // Window runs past the top of the address space
    '{24'hfff000, 16'h1234, 1'b1, 4'd1}
  };

  logic        vclk = 1'b0;
  logic        resetn;
  logic        fetch_en;
  byte_addr_t  fb_base;
  logic [15:0] mem_key;
  mem_word_t   ext_rdata;
  logic        ext_burst_ready;
  mem_req_t    ext_req;
  logic [4:0]  red;
  logic [4:0]  green;
  logic [4:0]  blue;
  logic        hsync;
  logic        vsync;
  logic        de;
  logic        mem_fault;

  int          cyc = 0;
  int          h_fall = -1;
  int          v_fall = -1;
  logic        h_prev = 1'b1;
  logic        v_prev = 1'b1;
  logic        de_prev = 1'b0;
  int          de_run = 0;
  int          de_lines = 0;
  byte_addr_t  frame_base;
  logic [15:0] frame_key;
  logic        frame_en = 1'b0;

  always #(CLK_PERIOD / 2) vclk = ~vclk;

  vga_scanout u_vga_scanout (
    .vclk            (vclk),
    .resetn          (resetn),
    .fetch_en        (fetch_en),
    .fb_base         (fb_base),
    .ext_rdata       (ext_rdata),
    .ext_burst_ready (ext_burst_ready),
    .ext_req         (ext_req),
    .red             (red),
    .green           (green),
    .blue            (blue),
    .hsync           (hsync),
    .vsync           (vsync),
    .de              (de)
  );

  fb_mem_model u_mem (
    .vclk     (vclk),
    .resetn   (resetn),
    .vsync    (vsync),
    .fetch_en (fetch_en),
    .fb_base  (fb_base),
    .key      (mem_key),
    .req      (ext_req),
    .rdata    (ext_rdata),
    .ready    (ext_burst_ready),
    .fault    (mem_fault)
  );

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
      $display("ERR %0t ns %s expected %0h got %0h", $time, name, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic wait_vsync_fall();
    do @(posedge vclk); while (!vsync);
    do @(posedge vclk); while (vsync);
  endtask

  task automatic check_pixel(input int x, input int y);
    byte_addr_t  a;
    logic [15:0] p;
    if (x >= WIN_X1 && x < WIN_X2 && y >= WIN_Y1 && y < WIN_Y2) begin
      // With fetching off the buffer still shows an older frame
      if (frame_en) begin
        a = frame_base + byte_addr_t'(((y - WIN_Y1) * WIN_W + x - WIN_X1) * BYTES_PER_PIXEL);
        p = a[16:1] ^ frame_key;
        check_value("red", int'(p[14:10]), int'(red));
        check_value("green", int'(p[9:5]), int'(green));
        check_value("blue", int'(p[4:0]), int'(blue));
      end
    end else begin
      check_value("red", 0, int'(red));
      check_value("green", 0, int'(green));
      check_value("blue", 0, int'(blue));
    end
  endtask

  // Outputs sampled on the falling edge, away from the register updates
  always @(negedge vclk) begin
    if (!resetn) begin
      assert (hsync && vsync) else begin
        $display("Sync pulse active during reset at %0t ns", $time);
        abort_run();
      end
    end else begin
      assert (!mem_fault) else begin
        $display("Memory model rejected a request before %0t ns", $time);
        abort_run();
      end
      if (h_prev && !hsync) begin
        if (h_fall >= 0) check_value("hsync period", H_TOTAL, cyc - h_fall);
        h_fall = cyc;
      end
      if (!h_prev && hsync) check_value("hsync width", H_SYNC_END - H_SYNC_START, cyc - h_fall);
      if (v_prev && !vsync) begin
        if (v_fall >= 0) check_value("vsync period", V_TOTAL * H_TOTAL, cyc - v_fall);
        v_fall = cyc;
        check_value("de lines", V_ACTIVE, de_lines);
        de_lines = 0;
      end
      if (!v_prev && vsync)
        check_value("vsync width", (V_SYNC_END - V_SYNC_START) * H_TOTAL, cyc - v_fall);
      if (de) begin
        // Settings in force when the frame starts
        if (de_run == 0 && de_lines == 0) begin
          frame_base = fb_base;
          frame_key  = mem_key;
          frame_en   = fetch_en;
        end
        check_pixel(de_run, de_lines);
        de_run++;
      end else if (de_prev) begin
        check_value("de width", H_ACTIVE, de_run);
        de_run = 0;
        de_lines++;
      end
      cyc++;
    end
    h_prev  = hsync;
    v_prev  = vsync;
    de_prev = de;
  end

  initial begin
    int i;
    resetn   <= 1'b0;
    fetch_en <= 1'b0;
    fb_base  <= '0;
    mem_key  <= '0;
    repeat (5) @(posedge vclk);
    resetn <= 1'b1;
    // Lead-in frame with fetching off, then each row starts at a vsync
    wait_vsync_fall();
    for (i = 0; i < NUM_ROWS; i++) begin
      fb_base  <= STIM_TAB[i].base;
      mem_key  <= STIM_TAB[i].key;
      fetch_en <= STIM_TAB[i].en;
      repeat (STIM_TAB[i].frames) wait_vsync_fall();
    end
    repeat (2) @(posedge vclk);
    if (mem_fault) begin
      $display("Memory model rejected a request at the end of the run");
      abort_run();
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  initial begin
    longint frames;
    int     i;
    frames = 1;
    for (i = 0; i < NUM_ROWS; i++) frames += longint'(STIM_TAB[i].frames);
    #(frames * H_TOTAL * V_TOTAL * CLK_PERIOD * 3 / 2);
    $display("Timeout, the run did not finish within %0d frame times", frames * 3 / 2);
    abort_run();
  end

endmodule

//--- filelist.f
source/vga_pkg.sv
source/video_timing.sv
source/line_fetch.sv
source/line_buffer.sv
source/pixel_out.sv
source/vga_scanout.sv
test/fb_mem_model.sv
test/tb_vga_scanout.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_vga_scanout
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
